// ==== verilog/vecPkg.sv ====
package vecPkg;

    localparam int ELEM_WID = 8;
    localparam int RES_WID = 24; // Covers sums of up to 256 elements.

    typedef enum logic [1:0] {
        opDot,
        opSum,
        opMax
    } opT;

    typedef enum logic {
        selA,
        selB
    } selT;

    // One streamed element with its routing tag and job opcode.
    typedef struct packed {
        selT target;
        opT op;
        logic [ELEM_WID-1:0] data;
    } elemT;

    typedef struct packed {
        opT op;
        logic [RES_WID-1:0] value;
    } resultT;

    typedef enum logic [1:0] {
        stIdle,
        stRun,
        stHold
    } reduceStateT;

endpackage

// ==== verilog/creditRx.sv ====
`timescale 1ns/1ps

module creditRx #(
    parameter int FIFO_DEPTH = 4
)(
    input logic clk_i,
    input logic rst_i,

    input vecPkg::elemT elem_i,
    input logic elemValid_i,

    output vecPkg::elemT head_o,
    output logic headValid_o,
    input logic pop_i,

    output logic credit_o
);

    localparam int PTR_WID = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_WID = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_WID-1:0] LAST_PTR = PTR_WID'(FIFO_DEPTH - 1);

    vecPkg::elemT mem [FIFO_DEPTH];

    logic [PTR_WID-1:0] wrPtr;
    logic [PTR_WID-1:0] rdPtr;
    logic [CNT_WID-1:0] count;

    function automatic logic [PTR_WID-1:0] advance(input logic [PTR_WID-1:0] ptr);
        return (ptr == LAST_PTR) ? '0 : ptr + 1'b1;
    endfunction

    assign headValid_o = count != '0;
    assign head_o = mem[rdPtr];

    // Host credits bound the occupancy, so a write is never refused.
    always_ff @(posedge clk_i) begin
        if (elemValid_i) begin
            mem[wrPtr] <= elem_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (elemValid_i) begin
                wrPtr <= advance(wrPtr);
            end
            if (pop_i) begin
                rdPtr <= advance(rdPtr);
            end
            if (elemValid_i && !pop_i) begin
                count <= count + 1'b1;
            end else if (!elemValid_i && pop_i) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            credit_o <= 1'b0;
        end else begin
            credit_o <= pop_i; // One credit back per popped element.
        end
    end

endmodule

// ==== verilog/vectorBuf.sv ====
`timescale 1ns/1ps

module vectorBuf #(
    parameter int DATA_WID = 8,
    parameter int BUF_SIZE = 4
)(
    input logic clk_i,
    input logic rst_i,

    input logic [DATA_WID-1:0] data_i,
    input logic dataValid_i,
    input logic clear_i,
    output logic accept_o,

    output logic [DATA_WID*BUF_SIZE-1:0] buffer_o,
    output logic isFull_o
);

    localparam int IDX_WID = $clog2(BUF_SIZE + 1);
    localparam logic [IDX_WID-1:0] FULL_IDX = IDX_WID'(BUF_SIZE);

    logic [IDX_WID-1:0] bufIdx;

    assign isFull_o = bufIdx == FULL_IDX;
    assign accept_o = dataValid_i && !isFull_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bufIdx <= '0;
        end else if (clear_i) begin
            bufIdx <= '0; // Old contents get overwritten before the next full.
        end else if (accept_o) begin
            bufIdx <= bufIdx + 1'b1;
        end
    end

    // Slot i holds the i-th element that arrived since the last clear.
    always_ff @(posedge clk_i) begin
        if (accept_o) begin
            buffer_o[bufIdx*DATA_WID +: DATA_WID] <= data_i;
        end
    end

endmodule

// ==== verilog/vecCtrl.sv ====
`timescale 1ns/1ps

module vecCtrl #(
    parameter int OUT_CREDITS = 2
)(
    input logic clk_i,
    input logic rst_i,

    input vecPkg::elemT head_i,
    input logic headValid_i,
    output logic pop_o,

    output logic validA_o,
    output logic validB_o,
    input logic acceptA_i,
    input logic acceptB_i,
    input logic fullA_i,
    input logic fullB_i,

    input logic busy_i,
    output logic launch_o,
    output vecPkg::opT op_o,

    input logic resValid_i,
    input logic resCredit_i,
    output logic sendOk_o
);

    localparam int CRD_WID = $clog2(OUT_CREDITS + 1);

    vecPkg::opT opReg;
    logic [CRD_WID-1:0] outCredit;

    // Only the head is offered; a blocked head holds back everything behind it.
    assign validA_o = headValid_i && (head_i.target == vecPkg::selA);
    assign validB_o = headValid_i && (head_i.target == vecPkg::selB);
    assign pop_o = (validA_o && acceptA_i) || (validB_o && acceptB_i);

    // Launch doubles as the clear of both buffers.
    assign launch_o = fullA_i && fullB_i && !busy_i;
    assign op_o = opReg;

    assign sendOk_o = outCredit != '0;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            opReg <= vecPkg::opDot;
        end else if (pop_o) begin
            opReg <= head_i.op; // Last accepted op wins.
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            outCredit <= CRD_WID'(OUT_CREDITS);
        end else if (resCredit_i && !resValid_i) begin
            outCredit <= outCredit + 1'b1;
        end else if (!resCredit_i && resValid_i) begin
            outCredit <= outCredit - 1'b1;
        end
    end

endmodule

// ==== verilog/vecReduce.sv ====
`timescale 1ns/1ps

module vecReduce #(
    parameter int BUF_SIZE = 4
)(
    input logic clk_i,
    input logic rst_i,

    input logic launch_i,
    input vecPkg::opT op_i,
    input logic [vecPkg::ELEM_WID*BUF_SIZE-1:0] vecA_i,
    input logic [vecPkg::ELEM_WID*BUF_SIZE-1:0] vecB_i,

    input logic sendOk_i,
    output logic busy_o,
    output vecPkg::resultT res_o,
    output logic resValid_o
);

    localparam int EW = vecPkg::ELEM_WID;
    localparam int RW = vecPkg::RES_WID;
    localparam int CNT_WID = (BUF_SIZE > 1) ? $clog2(BUF_SIZE) : 1;
    localparam logic [CNT_WID-1:0] LAST_CNT = CNT_WID'(BUF_SIZE - 1);

    vecPkg::reduceStateT state;
    vecPkg::opT opReg;

    logic [EW*BUF_SIZE-1:0] snapA;
    logic [EW*BUF_SIZE-1:0] snapB;
    logic [CNT_WID-1:0] cnt;
    logic [RW-1:0] acc;
    logic [RW-1:0] nextAcc;

    logic [EW-1:0] elemA;
    logic [EW-1:0] elemB;
    logic [2*EW-1:0] prod;
    logic [EW-1:0] larger;

    // Snapshots shift down, so the current pair is always in the low slot.
    assign elemA = snapA[EW-1:0];
    assign elemB = snapB[EW-1:0];
    assign prod = elemA * elemB;
    assign larger = (elemA > elemB) ? elemA : elemB;

    always_comb begin
        case (opReg)
            vecPkg::opDot: nextAcc = acc + RW'(prod);
            vecPkg::opSum: nextAcc = acc + RW'(elemA) + RW'(elemB);
            default: nextAcc = (RW'(larger) > acc) ? RW'(larger) : acc;
        endcase
    end

    assign busy_o = state != vecPkg::stIdle;
    assign resValid_o = (state == vecPkg::stHold) && sendOk_i;
    assign res_o.op = opReg;
    assign res_o.value = acc;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= vecPkg::stIdle;
            cnt <= '0;
        end else begin
            case (state)
                vecPkg::stIdle: begin
                    if (launch_i) begin
                        state <= vecPkg::stRun;
                        cnt <= '0;
                    end
                end
                vecPkg::stRun: begin
                    cnt <= cnt + 1'b1;
                    if (cnt == LAST_CNT) begin
                        state <= vecPkg::stHold;
                    end
                end
                default: begin
                    if (sendOk_i) begin
                        state <= vecPkg::stIdle; // Result taken this cycle.
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state == vecPkg::stIdle && launch_i) begin
            snapA <= vecA_i;
            snapB <= vecB_i;
            opReg <= op_i;
            acc <= '0;
        end else if (state == vecPkg::stRun) begin
            snapA <= snapA >> EW;
            snapB <= snapB >> EW;
            acc <= nextAcc;
        end
    end

endmodule

// ==== verilog/vecTop.sv ====
`timescale 1ns/1ps

module vecTop #(
    parameter int BUF_SIZE = 4,
    parameter int FIFO_DEPTH = 4,
    parameter int OUT_CREDITS = 2
)(
    input logic clk_i,
    input logic rst_i,

    input vecPkg::elemT elem_i,
    input logic elemValid_i,
    output logic credit_o,

    output vecPkg::resultT res_o,
    output logic resValid_o,
    input logic resCredit_i
);

    localparam int EW = vecPkg::ELEM_WID;

    vecPkg::elemT head;
    vecPkg::opT op;
    logic headValid;
    logic pop;
    logic validA;
    logic validB;
    logic acceptA;
    logic acceptB;
    logic fullA;
    logic fullB;
    logic [EW*BUF_SIZE-1:0] vecA;
    logic [EW*BUF_SIZE-1:0] vecB;
    logic busy;
    logic launch;
    logic sendOk;

    creditRx #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_creditRx (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .elem_i     (elem_i),
        .elemValid_i(elemValid_i),
        .head_o     (head),
        .headValid_o(headValid),
        .pop_i      (pop),
        .credit_o   (credit_o)
    );

    vectorBuf #(
        .DATA_WID(EW),
        .BUF_SIZE(BUF_SIZE)
    ) bufA (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .data_i     (head.data),
        .dataValid_i(validA),
        .clear_i    (launch),
        .accept_o   (acceptA),
        .buffer_o   (vecA),
        .isFull_o   (fullA)
    );

    vectorBuf #(
        .DATA_WID(EW),
        .BUF_SIZE(BUF_SIZE)
    ) bufB (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .data_i     (head.data),
        .dataValid_i(validB),
        .clear_i    (launch),
        .accept_o   (acceptB),
        .buffer_o   (vecB),
        .isFull_o   (fullB)
    );

    vecCtrl #(
        .OUT_CREDITS(OUT_CREDITS)
    ) i_vecCtrl (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .head_i     (head),
        .headValid_i(headValid),
        .pop_o      (pop),
        .validA_o   (validA),
        .validB_o   (validB),
        .acceptA_i  (acceptA),
        .acceptB_i  (acceptB),
        .fullA_i    (fullA),
        .fullB_i    (fullB),
        .busy_i     (busy),
        .launch_o   (launch),
        .op_o       (op),
        .resValid_i (resValid_o),
        .resCredit_i(resCredit_i),
        .sendOk_o   (sendOk)
    );

    vecReduce #(
        .BUF_SIZE(BUF_SIZE)
    ) i_vecReduce (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .launch_i  (launch),
        .op_i      (op),
        .vecA_i    (vecA),
        .vecB_i    (vecB),
        .sendOk_i  (sendOk),
        .busy_o    (busy),
        .res_o     (res_o),
        .resValid_o(resValid_o)
    );

endmodule

// ==== verification/vecTb.sv ====
`timescale 1ns/1ps

module vecTb;

    localparam int BUF_SIZE = 4;
    localparam int FIFO_DEPTH = 4;
    localparam int OUT_CREDITS = 2;
    localparam int NJOBS = 7;
    localparam int RESET_CYCLES = 10;
    localparam int HOLD_CYCLES = 100; // Receiver keeps its credits this long after reset.
    localparam int EW = vecPkg::ELEM_WID;

    // Pattern bit k set means the k-th element of the job goes to vector B.
    typedef struct packed {
        vecPkg::opT op;
        logic [EW*BUF_SIZE-1:0] a;
        logic [EW*BUF_SIZE-1:0] b;
        logic [2*BUF_SIZE-1:0] pattern;
        logic [vecPkg::RES_WID-1:0] expVal;
    } jobT;

    logic clk_i = 1'b0;
    logic rst_i;
    vecPkg::elemT elem_i;
    logic elemValid_i;
    logic credit_o;
    vecPkg::resultT res_o;
    logic resValid_o;
    logic resCredit_i;

    jobT jobs [NJOBS];
    logic [31:0] sendRng = 32'h43ec_ec29;
    logic [31:0] recvRng = ~32'h43ec_ec29;
    int sent = 0;
    int creditsBack = 0;
    int received = 0;
    int returned = 0;
    int recvCycles = 0;

    vecTop i_dut (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .elem_i     (elem_i),
        .elemValid_i(elemValid_i),
        .credit_o   (credit_o),
        .res_o      (res_o),
        .resValid_o (resValid_o),
        .resCredit_i(resCredit_i)
    );

    always #2 clk_i = ~clk_i;

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int hostCredits();
        return FIFO_DEPTH - sent + creditsBack;
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            abortRun("Value mismatch");
        end
    endtask

    // Random idle gap first, then wait for a credit before driving the element.
    task automatic sendElem(input vecPkg::elemT e);
        int gap;
        sendRng = nextRandom(sendRng);
        gap = sendRng % 4;
        @(posedge clk_i);
        while (gap > 0 || hostCredits() == 0) begin
            elemValid_i <= 1'b0;
            if (gap > 0) begin
                gap--;
            end
            @(posedge clk_i);
        end
        elem_i <= e;
        elemValid_i <= 1'b1;
        sent++;
    endtask

    // Credits and results are sampled mid-cycle, where they are stable.
    always @(negedge clk_i) begin
        if (!rst_i) begin
            if (credit_o) begin
                creditsBack++;
            end
            if (resValid_o) begin
                if (received >= NJOBS) begin
                    abortRun("A result arrived after the last job was done");
                end else begin
                    checkEq("res_o.op", 32'(res_o.op), 32'(jobs[received].op));
                    checkEq("res_o.value", 32'(res_o.value), 32'(jobs[received].expVal));
                    received++;
                    if (received - returned > OUT_CREDITS) begin
                        abortRun("A result was sent without a free receiver slot");
                    end
                end
            end
        end
    end

    // Receiver frees its slots at random once the hold phase is over.
    always @(posedge clk_i) begin
        if (rst_i) begin
            resCredit_i <= 1'b0;
        end else begin
            recvCycles++;
            if (recvCycles == HOLD_CYCLES && received != OUT_CREDITS) begin
                abortRun($sformatf("%0d results came out while credits were held, expected %0d",
                                   received, OUT_CREDITS));
            end
            recvRng = nextRandom(recvRng);
            if (recvCycles > HOLD_CYCLES && received > returned && recvRng[0]) begin
                resCredit_i <= 1'b1;
                returned++;
            end else begin
                resCredit_i <= 1'b0;
            end
        end
    end

    initial begin
        repeat (RESET_CYCLES + NJOBS * (3 * BUF_SIZE + 40)) @(posedge clk_i);
        abortRun($sformatf("Watchdog expired with %0d of %0d results received",
                           received, NJOBS));
    end

    initial begin
        vecPkg::elemT e;
        int aIdx;
        int bIdx;
        rst_i = 1'b1;
        elem_i = '0;
        elemValid_i = 1'b0;
        resCredit_i = 1'b0;
        jobs[0] = '{vecPkg::opDot, 32'h0403_0201, 32'h0807_0605, 8'b1010_1010, 24'd70};
        jobs[1] = '{vecPkg::opSum, 32'h281e_140a, 32'h0403_0201, 8'b1111_0000, 24'd110};
        jobs[2] = '{vecPkg::opMax, 32'h0907_c803, 32'h00c9_3264, 8'b0110_0110, 24'd201};
        jobs[3] = '{vecPkg::opDot, 32'hffff_ffff, 32'hffff_ffff, 8'b1001_1001, 24'd260100};
        jobs[4] = '{vecPkg::opSum, 32'hffff_ffff, 32'hffff_ffff, 8'b1100_1100, 24'd2040};
        jobs[5] = '{vecPkg::opMax, 32'h0000_0000, 32'h1100_0000, 8'b0011_0011, 24'd17};
        jobs[6] = '{vecPkg::opDot, 32'h0000_0001, 32'h0900_0000, 8'b0000_1111, 24'd0};

        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;
        repeat (3) begin
            @(negedge clk_i);
            checkEq("credit_o", 32'(credit_o), 32'd0);
            checkEq("resValid_o", 32'(resValid_o), 32'd0);
        end

        for (int j = 0; j < NJOBS; j++) begin
            aIdx = 0;
            bIdx = 0;
            for (int k = 0; k < 2 * BUF_SIZE; k++) begin
                e.op = jobs[j].op;
                if (jobs[j].pattern[k]) begin
                    e.target = vecPkg::selB;
                    e.data = jobs[j].b[EW*bIdx +: EW];
                    bIdx++;
                end else begin
                    e.target = vecPkg::selA;
                    e.data = jobs[j].a[EW*aIdx +: EW];
                    aIdx++;
                end
                sendElem(e);
            end
        end
        @(posedge clk_i);
        elemValid_i <= 1'b0;

        wait (received == NJOBS);
        repeat (4) @(posedge clk_i);
        checkEq("credit_o pulses", 32'(creditsBack), 32'(sent));
        $display("Test passed");
        $finish;
    end

endmodule

// ==== compile.f ====
verilog/vecPkg.sv
verilog/creditRx.sv
verilog/vectorBuf.sv
verilog/vecCtrl.sv
verilog/vecReduce.sv
verilog/vecTop.sv
verification/vecTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log for a failure.
rm -f sim.log
verilator --binary --top-module vecTb -f compile.f &&
    { ./obj_dir/VvecTb > sim.log 2>&1; true; } &&
    test -s sim.log &&
    ! grep -q "Test failed" sim.log &&
    echo "Simulation ok, see sim.log" ||
    { echo "Simulation failed, see sim.log"; exit 1; }
